//--- verilog.f
+incdir+design
design/ualink_pkg.sv
design/ualink_rx_fifo.sv
design/ualink_line_ram.sv
design/ualink_cmd_engine.sv
design/ualink_node_top.sv
tests/ualink_properties.sv
tests/ualink_tb.sv

//--- Makefile
# Verilator build and run of the packet command node testbench

VERILATOR ?= verilator
TOP       ?= ualink_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- tests/ualink_tb.sv
// ==============================
// packet command node testbench
// directed tests for pass-through,
// memory bursts and back-pressure
// ==============================

`timescale 1ns/1ps

`include "ualink_defs.svh"

module ualink_tb
   import ualink_pkg::*;
();

   localparam int TEST_WORDS = 122; // words in and out over all tests
   localparam int RX_LIMIT   = 200; // idle cycles before a packet counts as missing
   localparam ul_opcode_t OP_OTHER = 16'h0A5A;

   logic     axi_aclk;
   logic     axi_resetn;
   ul_data_t s_axis_tdata;
   logic     s_axis_tlast;
   logic     s_axis_tvalid;
   logic     s_axis_tready;
   ul_data_t m_axis_tdata;
   logic     m_axis_tlast;
   logic     m_axis_tvalid;
   logic     m_axis_tready;

   int       data_errors;
   int       last_errors;
   int       packet_errors;
   int       ingress_stalls;
   ul_data_t model_mem [256]; // expected line memory contents
   bit       model_known [256];

   initial begin
      axi_aclk = 1'b0;
      forever #4 axi_aclk = ~axi_aclk;
   end

   ualink_node_top ualink_node_top_inst (.*);

   initial begin
      repeat (TEST_WORDS * 40) @(posedge axi_aclk);
      $display("watchdog: tests did not finish within %0d cycles", TEST_WORDS * 40);
      $display("Done: errors found");
      $finish;
   end

   function automatic ul_data_t random_word();
      return {$urandom, $urandom};
   endfunction

   // opcode in 63:48 and address in 47:40 with the rest ignored
   function automatic ul_data_t make_header(ul_opcode_t op, ul_addr_t addr);
      return {op, addr, 8'h00, $urandom};
   endfunction

   task automatic check_data(input string name, input ul_data_t exp, input ul_data_t act);
      if (act !== exp) begin
         data_errors++;
         $display("** Error %s: expected 0x%h, actual 0x%h", name, exp, act);
      end
   endtask

   task automatic check_last(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         last_errors++;
         $display("** Error %s: expected 0x%h, actual 0x%h", name, exp, act);
      end
   endtask

   task automatic send_packet(input ul_data_t words[$]);
      for (int i = 0; i < words.size(); i++) begin
         @(negedge axi_aclk);
         s_axis_tdata  = words[i];
         s_axis_tlast  = (i == words.size() - 1);
         s_axis_tvalid = 1'b1;
         while (!s_axis_tready) begin // beat held while the FIFO is full
            ingress_stalls++;
            @(negedge axi_aclk);
         end
      end
      @(negedge axi_aclk);
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
   endtask

   task automatic receive_packet(input bit random_ready, output ul_data_t words[$],
                                 output logic lasts[$]);
      int idle;
      bit got_last;
      words.delete();
      lasts.delete();
      idle     = 0;
      got_last = 1'b0;
      while (!got_last && idle < RX_LIMIT) begin
         @(negedge axi_aclk);
         m_axis_tready = random_ready ? 1'($urandom & 1) : 1'b1;
         if (m_axis_tvalid && m_axis_tready) begin
            words.push_back(m_axis_tdata);
            lasts.push_back(m_axis_tlast);
            got_last = m_axis_tlast;
            idle     = 0;
         end else begin
            idle++;
         end
      end
      @(negedge axi_aclk);
      m_axis_tready = 1'b0;
      if (!got_last) begin
         packet_errors++;
         $display("output packet missing: no tlast seen within %0d idle cycles", RX_LIMIT);
      end
   endtask

   task automatic check_packet(input ul_data_t exp[$], input bit known[$],
                               input ul_data_t got[$], input logic got_last[$]);
      if (got.size() != exp.size()) begin
         packet_errors++;
         $display("output packet has %0d words where %0d were expected",
                  got.size(), exp.size());
      end
      for (int i = 0; i < got.size() && i < exp.size(); i++) begin
         if (known[i]) begin
            check_data("m_axis_tdata", exp[i], got[i]);
         end
         check_last("m_axis_tlast", i == exp.size() - 1, got_last[i]);
      end
   endtask

   task automatic expect_idle(input int cycles);
      bit seen;
      seen = 1'b0;
      for (int i = 0; i < cycles && !seen; i++) begin
         @(negedge axi_aclk);
         seen = m_axis_tvalid;
      end
      if (seen) begin
         packet_errors++;
         $display("extra output packet appeared where none was expected");
      end
   endtask

   task automatic test_pass_through(input int len, input bit random_ready);
      ul_data_t pkt[$];
      bit       known[$];
      ul_data_t got[$];
      logic     got_last[$];
      pkt.push_back(make_header(OP_OTHER, ul_addr_t'($urandom)));
      known.push_back(1'b1);
      for (int i = 1; i < len; i++) begin
         pkt.push_back(random_word());
         known.push_back(1'b1);
      end
      fork
         send_packet(pkt);
         receive_packet(random_ready, got, got_last);
      join
      check_packet(pkt, known, got, got_last);
      expect_idle(10);
   endtask

   task automatic test_write(input ul_addr_t addr);
      ul_data_t pkt[$];
      ul_addr_t a;
      pkt.push_back(make_header(`UL_OP_WRITE, addr));
      for (int i = 0; i < `UL_BURST_WORDS; i++) begin
         a = ul_addr_t'(addr + i); // wraps at 256
         model_mem[a]   = random_word();
         model_known[a] = 1'b1;
         pkt.push_back(model_mem[a]);
      end
      send_packet(pkt);
      expect_idle(20); // writes answer nothing
   endtask

   task automatic test_read(input ul_addr_t addr, input bit random_ready);
      ul_data_t hdr[$];
      ul_data_t exp[$];
      bit       known[$];
      ul_data_t got[$];
      logic     got_last[$];
      hdr.push_back(make_header(`UL_OP_READ, addr));
      for (int i = 0; i < `UL_BURST_WORDS; i++) begin
         exp.push_back(model_mem[ul_addr_t'(addr + i)]);
         known.push_back(model_known[ul_addr_t'(addr + i)]);
      end
      fork
         send_packet(hdr);
         receive_packet(random_ready, got, got_last);
      join
      check_packet(exp, known, got, got_last);
      expect_idle(10);
   endtask

   // egress held off until the FIFO has filled
   task automatic test_ingress_backpressure();
      ul_data_t pkt[$];
      bit       known[$];
      ul_data_t got[$];
      logic     got_last[$];
      int       stalls_before;
      stalls_before = ingress_stalls;
      pkt.push_back(make_header(OP_OTHER, 8'h00));
      known.push_back(1'b1);
      for (int i = 1; i < 24; i++) begin
         pkt.push_back(random_word());
         known.push_back(1'b1);
      end
      fork
         send_packet(pkt);
         begin
            for (int i = 0; i < 100 && ingress_stalls == stalls_before; i++) begin
               @(negedge axi_aclk);
            end
            repeat (4) @(negedge axi_aclk);
            receive_packet(1'b0, got, got_last);
         end
      join
      if (ingress_stalls == stalls_before) begin
         packet_errors++;
         $display("s_axis_tready never fell although the FIFO should have filled");
      end
      check_packet(pkt, known, got, got_last);
      expect_idle(10);
   endtask

   initial begin
      int total;
      int assert_errors;
      void'($urandom(99));
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      repeat (4) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_resetn = 1'b1;

      test_pass_through(5, 1'b0);
      test_write(8'h10);
      test_read(8'h10, 1'b0);
      test_write(8'hFC); // burst crosses the top of memory
      test_read(8'h00, 1'b0);
      test_write(8'h40);
      test_read(8'h40, 1'b1);
      test_pass_through(5, 1'b1);
      test_ingress_backpressure();

      assert_errors = ualink_node_top_inst.ualink_properties_inst.failures;
      total = data_errors + last_errors + packet_errors + assert_errors;
      $display("errors: data %0d, tlast %0d, packet %0d, assertion %0d", data_errors,
               last_errors, packet_errors, assert_errors);
      if (total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- tests/ualink_properties.sv
// ==============================
// stream port assertions
// bound to the node top level
// ==============================

`timescale 1ns/1ps

module ualink_properties
   import ualink_pkg::*;
(
   input logic     axi_aclk,
   input logic     axi_resetn,
   input ul_data_t s_axis_tdata,
   input logic     s_axis_tlast,
   input logic     s_axis_tvalid,
   input logic     s_axis_tready,
   input ul_data_t m_axis_tdata,
   input logic     m_axis_tlast,
   input logic     m_axis_tvalid,
   input logic     m_axis_tready
);

   int failures; // failed assertion count

   // egress quiet right after reset
   assert property (@(posedge axi_aclk) !axi_resetn |=> !m_axis_tvalid)
      else begin
         failures++;
         $error("m_axis_tvalid high in the cycle after reset");
      end

   assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=>
         m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
      else begin
         failures++;
         $error("egress beat changed while stalled");
      end

   // guards the testbench sender
   assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      s_axis_tvalid && !s_axis_tready |=>
         s_axis_tvalid && $stable(s_axis_tdata) && $stable(s_axis_tlast))
      else begin
         failures++;
         $error("ingress beat changed while stalled");
      end

endmodule

bind ualink_node_top ualink_properties ualink_properties_inst (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .s_axis_tdata  (s_axis_tdata),
   .s_axis_tlast  (s_axis_tlast),
   .s_axis_tvalid (s_axis_tvalid),
   .s_axis_tready (s_axis_tready),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tlast  (m_axis_tlast),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready)
);

//--- design/ualink_node_top.sv
// ============================
// packet command node
// ingress FIFO, command engine and
// line memory between two streams
// ============================

`timescale 1ns/1ps

module ualink_node_top
   import ualink_pkg::*;
(
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   // ingress stream
   input  ul_data_t s_axis_tdata,
   input  logic     s_axis_tlast,
   input  logic     s_axis_tvalid,
   output logic     s_axis_tready,
   // egress stream
   output ul_data_t m_axis_tdata,
   output logic     m_axis_tlast,
   output logic     m_axis_tvalid,
   input  logic     m_axis_tready
);

   ul_beat_t s_beat;
   ul_beat_t head;
   logic     head_valid;
   logic     pop;
   logic     wr_en;
   ul_addr_t wr_addr;
   ul_data_t wr_data;
   logic     rd_en;
   ul_addr_t rd_addr;
   ul_data_t rd_data;
   ul_beat_t m_beat;

   assign s_beat.data  = s_axis_tdata;
   assign s_beat.last  = s_axis_tlast;
   assign m_axis_tdata = m_beat.data;
   assign m_axis_tlast = m_beat.last;

   ualink_rx_fifo rx_fifo_inst (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .wr_beat    (s_beat),
      .wr_valid   (s_axis_tvalid),
      .wr_ready   (s_axis_tready),
      .head       (head),
      .head_valid (head_valid),
      .pop        (pop)
   );

   ualink_cmd_engine cmd_engine_inst (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .head       (head),
      .head_valid (head_valid),
      .pop        (pop),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .rd_en      (rd_en),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .m_beat     (m_beat),
      .m_valid    (m_axis_tvalid),
      .m_ready    (m_axis_tready)
   );

   ualink_line_ram line_ram_inst (
      .axi_aclk (axi_aclk),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

endmodule

//--- design/ualink_cmd_engine.sv
// ============================
// command engine
// decodes packet headers, runs memory write
// and read bursts, forwards other packets
// ============================

`timescale 1ns/1ps

`include "ualink_defs.svh"

module ualink_cmd_engine
   import ualink_pkg::*;
(
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   // ingress FIFO head
   input  ul_beat_t head,
   input  logic     head_valid,
   output logic     pop,
   // line memory
   output logic     wr_en,
   output ul_addr_t wr_addr,
   output ul_data_t wr_data,
   output logic     rd_en,
   output ul_addr_t rd_addr,
   input  ul_data_t rd_data,
   // egress stream
   output ul_beat_t m_beat,
   output logic     m_valid,
   input  logic     m_ready
);

   localparam ul_burst_cnt_t LAST_IDX = ul_burst_cnt_t'(`UL_BURST_WORDS - 1);

   ul_state_e     state;
   ul_state_e     state_next;
   ul_burst_cnt_t burst_cnt;  // beats written or reads issued
   ul_addr_t      base_addr;
   ul_beat_t      resp_beat;  // read response register
   logic          resp_valid;
   logic          rd_pending; // memory word waiting in rd_data
   logic          rd_last;    // pending word is the last of the burst
   logic          rd_done;    // all reads of the burst issued
   logic          rd_load;

   ul_opcode_t    hdr_op;
   ul_addr_t      hdr_addr;
   logic          is_write;
   logic          is_read;

   // header fields
   assign hdr_op   = head.data[`UL_OP_MSB -: 16];
   assign hdr_addr = head.data[`UL_ADDR_MSB -: `UL_ADDR_W];
   assign is_write = (hdr_op == `UL_OP_WRITE);
   assign is_read  = (hdr_op == `UL_OP_READ);

   // addresses wrap in 8 bits
   assign wr_addr = base_addr + ul_addr_t'(burst_cnt);
   assign rd_addr = base_addr + ul_addr_t'(burst_cnt);
   assign wr_data = head.data;

   // move returned word into the response register once it is free
   assign rd_load = rd_pending && (!resp_valid || m_ready);

   always_comb begin
      state_next = state;
      pop        = 1'b0;
      wr_en      = 1'b0;
      rd_en      = 1'b0;
      m_valid    = 1'b0;
      m_beat     = resp_beat;
      case (state)
         HEADER: begin
            if (head_valid) begin
               if (is_write || is_read) begin
                  pop        = 1'b1; // command headers are consumed here
                  state_next = is_write ? WRITE : READ;
               end else begin
                  state_next = PASS; // header goes out with the packet
               end
            end
         end
         PASS: begin
            m_beat  = head;
            m_valid = head_valid;
            pop     = head_valid && m_ready;
            if (pop && head.last) begin
               state_next = HEADER;
            end
         end
         WRITE: begin
            pop   = head_valid;
            wr_en = head_valid;
            if (head_valid && burst_cnt == LAST_IDX) begin
               state_next = HEADER;
            end
         end
         READ: begin
            m_valid = resp_valid;
            rd_en   = !rd_done && (!resp_valid || m_ready);
            if (resp_valid && m_ready && resp_beat.last) begin
               state_next = HEADER;
            end
         end
         default: state_next = HEADER;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state      <= HEADER;
         burst_cnt  <= '0;
         resp_valid <= 1'b0;
         rd_pending <= 1'b0;
         rd_last    <= 1'b0;
         rd_done    <= 1'b0;
      end else begin
         state <= state_next;
         if (state == HEADER) begin
            burst_cnt <= '0;
            rd_done   <= 1'b0;
         end else if (wr_en || rd_en) begin
            burst_cnt <= burst_cnt + 1'b1; // wraps to zero after the 8th
         end
         if (rd_en && burst_cnt == LAST_IDX) begin
            rd_done <= 1'b1;
         end
         if (rd_en) begin
            rd_pending <= 1'b1;
            rd_last    <= (burst_cnt == LAST_IDX);
         end else if (rd_load) begin
            rd_pending <= 1'b0;
         end
         if (rd_load) begin
            resp_valid <= 1'b1;
         end else if (resp_valid && m_ready) begin
            resp_valid <= 1'b0;
         end
      end
   end

   // payload registers
   always_ff @(posedge axi_aclk) begin
      if (state == HEADER && pop) begin
         base_addr <= hdr_addr;
      end
      if (rd_load) begin
         resp_beat.data <= rd_data;
         resp_beat.last <= rd_last;
      end
   end

endmodule

//--- design/ualink_line_ram.sv
// ============================
// line memory
// 256 words, one write port and
// one registered read port
// ============================

`timescale 1ns/1ps

`include "ualink_defs.svh"

module ualink_line_ram
   import ualink_pkg::*;
(
   input  logic     axi_aclk,
   input  logic     wr_en,
   input  ul_addr_t wr_addr,
   input  ul_data_t wr_data,
   input  logic     rd_en,
   input  ul_addr_t rd_addr,
   output ul_data_t rd_data
);

   localparam int WORDS = 1 << `UL_ADDR_W;

   ul_data_t mem [WORDS];

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
      if (rd_en) begin
         rd_data <= mem[rd_addr]; // held until the next read
      end
   end

endmodule

//--- design/ualink_rx_fifo.sv
// ============================
// ingress FIFO
// fall-through buffer of stream beats,
// head visible without read latency
// ============================

`timescale 1ns/1ps

`include "ualink_defs.svh"

module ualink_rx_fifo
   import ualink_pkg::*;
#(
   parameter int DEPTH_LOG2 = `UL_FIFO_DEPTH_LOG2
) (
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   input  ul_beat_t wr_beat,
   input  logic     wr_valid,
   output logic     wr_ready,
   output ul_beat_t head,
   output logic     head_valid,
   input  logic     pop
);

   localparam int DEPTH = 1 << DEPTH_LOG2;

   ul_beat_t                mem [DEPTH];
   logic [DEPTH_LOG2-1:0]   wr_ptr;
   logic [DEPTH_LOG2-1:0]   rd_ptr;
   logic [DEPTH_LOG2:0]     count; // one extra bit to tell full from empty
   logic                    push;

   assign wr_ready   = (count != (DEPTH_LOG2 + 1)'(DEPTH));
   assign head_valid = (count != '0);
   assign head       = mem[rd_ptr]; // fall-through head
   assign push       = wr_valid && wr_ready;

   // beat storage
   always_ff @(posedge axi_aclk) begin
      if (push) begin
         mem[wr_ptr] <= wr_beat;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1; // caller only pops a valid head
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // both or neither
         endcase
      end
   end

endmodule

//--- design/ualink_pkg.sv
// ============================
// ualink node types
// words, addresses, stream beat
// and engine states
// ============================

`include "ualink_defs.svh"

package ualink_pkg;

   // one stream or memory word
   typedef logic [`UL_DATA_W-1:0] ul_data_t;

   // line memory address wrapping at 256
   typedef logic [`UL_ADDR_W-1:0] ul_addr_t;

   // opcode field of a header word
   typedef logic [15:0] ul_opcode_t;

   // beat index inside an 8 word burst
   typedef logic [$clog2(`UL_BURST_WORDS)-1:0] ul_burst_cnt_t;

   // one AXI-Stream beat with every byte valid
   typedef struct packed {
      ul_data_t data;
      logic     last;
   } ul_beat_t;

   typedef enum logic [1:0] {
      HEADER, // waiting for a packet head
      PASS,   // forwarding a foreign packet
      WRITE,  // storing burst data
      READ    // streaming burst data out
   } ul_state_e;

endpackage

//--- design/ualink_defs.svh
// ============================
// ualink node shared constants
// stream and memory widths, FIFO depth,
// burst length and command opcodes
// ============================

`ifndef UALINK_DEFS_SVH
`define UALINK_DEFS_SVH

// stream and memory word
`define UL_DATA_W 64
`define UL_ADDR_W 8

// ingress buffer of 16 beats by default
`define UL_FIFO_DEPTH_LOG2 4

// words per read or write burst
`define UL_BURST_WORDS 8

// header layout with opcode in 63:48 and start address in 47:40
`define UL_OP_WRITE 16'h0245
`define UL_OP_READ 16'h0145
`define UL_OP_MSB 63
`define UL_ADDR_MSB 47

`endif
